//--- hdl/fifo_cfg_pkg.sv
// FIFO configuration package
// Default sizes and flag thresholds plus the width helpers derived from them
`default_nettype none

package fifo_cfg_pkg;

   // ------------------------------------------------
   // Default sizes
   // ------------------------------------------------
   localparam int DEF_DATA_W = 8;     // Data word width
   localparam int DEF_ADDR_W = 4;     // Depth of 16 words

   // ------------------------------------------------
   // Static flag thresholds
   // ------------------------------------------------
   localparam int DEF_AFULL_VAL  = 12;  // Almost full at or above
   localparam int DEF_AEMPTY_VAL = 3;   // Almost empty at or below

   // Level needs one more bit than the address
   // so that a full FIFO reads as the depth and not as zero
   function automatic int lvl_w(input int addr_w);
      return addr_w + 1;
   endfunction

   // Number of words for a given address width
   function automatic int depth_of(input int addr_w);
      return 1 << addr_w;
   endfunction

endpackage

`default_nettype wire

//--- hdl/fifo_types_pkg.sv
// FIFO bus types
// Packed structs for the write request, RAM write port, status and read response
`default_nettype none

package fifo_types_pkg;

   localparam int DW = fifo_cfg_pkg::DEF_DATA_W;
   localparam int AW = fifo_cfg_pkg::DEF_ADDR_W;
   localparam int LW = fifo_cfg_pkg::lvl_w(fifo_cfg_pkg::DEF_ADDR_W);

   // Write request from the producer
   typedef struct packed {
      logic          en;    // Write enable
      logic [DW-1:0] data;  // Word to store
   } wr_req_t;

   // Write port into the RAM
   typedef struct packed {
      logic          en;
      logic [AW-1:0] addr;
      logic [DW-1:0] data;
   } mem_wr_t;

   // Registered status seen by both sides
   typedef struct packed {
      logic          full;
      logic          afull;
      logic          empty;
      logic          aempty;
      logic [LW-1:0] level;  // Words held, 0 to depth
   } fifo_status_t;

   // Read response, valid one edge after an accepted read
   typedef struct packed {
      logic          dvld;
      logic [DW-1:0] data;
   } rd_resp_t;

endpackage

`default_nettype wire

//--- hdl/fifo_wr_ctrl.sv
// FIFO write controller
// Gates writes against full, keeps the wrapping write address and
// registers the write acknowledge and overflow pulses
`timescale 1ns/1ps
`default_nettype none

module fifo_wr_ctrl #(
   parameter int DATA_W = fifo_cfg_pkg::DEF_DATA_W,
   parameter int ADDR_W = fifo_cfg_pkg::DEF_ADDR_W
) (
   input  logic                    pos_clk,
   input  logic                    aresetn,
   input  fifo_types_pkg::wr_req_t wr_req_i,
   input  logic                    full_i,
   output fifo_types_pkg::mem_wr_t mem_wr_o,
   output logic                    wr_accept_o,
   output logic                    wack_o,
   output logic                    overflow_o
);

   localparam int DEPTH = fifo_cfg_pkg::depth_of(ADDR_W);

   logic [ADDR_W-1:0] wr_addr_q;   // Next slot to write
   logic [DATA_W-1:0] wr_data;
   logic              wr_accept;   // Request that gets in
   logic              wack_q;
   logic              overflow_q;

   // Full is registered, so no loop through the occupancy tracker
   assign wr_accept = wr_req_i.en & ~full_i;
   assign wr_data   = wr_req_i.data;

   // ------------------------------------------------
   // RAM write port
   // ------------------------------------------------
   assign mem_wr_o.en   = wr_accept;
   assign mem_wr_o.addr = wr_addr_q;
   assign mem_wr_o.data = wr_data;   // Straight from the producer

   // Address advances only on accepted writes
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wr_addr_q <= '0;
      end else if (wr_accept) begin
         if (wr_addr_q == ADDR_W'(DEPTH - 1)) begin
            wr_addr_q <= '0;                // Wrap at the depth
         end else begin
            wr_addr_q <= wr_addr_q + 1'b1;
         end
      end
   end

   // Handshake pulses, one edge after the request
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         wack_q     <= 1'b0;
         overflow_q <= 1'b0;
      end else begin
         wack_q     <= wr_accept;
         overflow_q <= wr_req_i.en & full_i;  // Refused request
      end
   end

   assign wr_accept_o = wr_accept;
   assign wack_o      = wack_q;
   assign overflow_o  = overflow_q;

   // Full is set only by a write that got in
   a_full_after_write : assert property (@(posedge pos_clk) disable iff (!aresetn)
      $rose(full_i) |-> $past(wr_accept));

endmodule

`default_nettype wire

//--- hdl/fifo_occupancy.sv
// FIFO occupancy tracker
// Binary level counter driven by the two accept pulses, with registered
// full, almost full, empty and almost empty flags
`timescale 1ns/1ps
`default_nettype none

module fifo_occupancy #(
   parameter int ADDR_W     = fifo_cfg_pkg::DEF_ADDR_W,
   parameter int AFULL_VAL  = fifo_cfg_pkg::DEF_AFULL_VAL,
   parameter int AEMPTY_VAL = fifo_cfg_pkg::DEF_AEMPTY_VAL
) (
   input  logic                         pos_clk,
   input  logic                         aresetn,
   input  logic                         wr_accept_i,
   input  logic                         rd_accept_i,
   output fifo_types_pkg::fifo_status_t status_o
);

   localparam int LVL_W = fifo_cfg_pkg::lvl_w(ADDR_W);
   localparam int DEPTH = fifo_cfg_pkg::depth_of(ADDR_W);

   logic [LVL_W-1:0] level_q;
   logic [LVL_W-1:0] level_d;    // Level after this edge
   logic             full_q;
   logic             afull_q;
   logic             empty_q;
   logic             aempty_q;

   // ------------------------------------------------
   // Next level
   // ------------------------------------------------
   always_comb begin
      level_d = level_q;
      if (wr_accept_i && !rd_accept_i) begin
         level_d = level_q + 1'b1;          // Write only
      end else if (rd_accept_i && !wr_accept_i) begin
         level_d = level_q - 1'b1;          // Read only
      end
      // Both or neither leaves the level alone
   end

   // ------------------------------------------------
   // Level and flags
   // ------------------------------------------------
   // Flags come from the next level so they move on the same edge
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         level_q  <= '0;
         full_q   <= 1'b0;
         afull_q  <= 1'b0;
         empty_q  <= 1'b1;    // Starts empty
         aempty_q <= 1'b1;
      end else begin
         level_q  <= level_d;
         full_q   <= (level_d == LVL_W'(DEPTH));
         afull_q  <= (level_d >= LVL_W'(AFULL_VAL));
         empty_q  <= (level_d == '0);
         aempty_q <= (level_d <= LVL_W'(AEMPTY_VAL));
      end
   end

   assign status_o.full   = full_q;
   assign status_o.afull  = afull_q;
   assign status_o.empty  = empty_q;
   assign status_o.aempty = aempty_q;
   assign status_o.level  = level_q;

   // Both controllers gate on these flags, so no accept slips past a limit
   a_accept_in_limits : assert property (@(posedge pos_clk) disable iff (!aresetn)
      !(wr_accept_i && full_q) && !(rd_accept_i && empty_q));

   // Counter stays inside the storage
   a_level_in_range : assert property (@(posedge pos_clk) disable iff (!aresetn)
      level_q <= LVL_W'(DEPTH));

endmodule

`default_nettype wire

//--- hdl/fifo_rd_ctrl.sv
// FIFO read controller
// Gates reads against empty, keeps the wrapping read address and
// registers the data-valid and underflow pulses
`timescale 1ns/1ps
`default_nettype none

module fifo_rd_ctrl #(
   parameter int ADDR_W = fifo_cfg_pkg::DEF_ADDR_W
) (
   input  logic              pos_clk,
   input  logic              aresetn,
   input  logic              rd_en_i,
   input  logic              empty_i,
   output logic [ADDR_W-1:0] rd_addr_o,
   output logic              rd_accept_o,
   output logic              dvld_o,
   output logic              underflow_o
);

   localparam int DEPTH = fifo_cfg_pkg::depth_of(ADDR_W);

   logic [ADDR_W-1:0] rd_addr_q;   // Oldest word
   logic              rd_accept;
   logic              dvld_q;
   logic              underflow_q;

   // Empty is registered in the occupancy tracker
   assign rd_accept = rd_en_i & ~empty_i;

   // ------------------------------------------------
   // Read address
   // ------------------------------------------------
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         rd_addr_q <= '0;
      end else if (rd_accept) begin
         if (rd_addr_q == ADDR_W'(DEPTH - 1)) begin
            rd_addr_q <= '0;                // Wrap at the depth
         end else begin
            rd_addr_q <= rd_addr_q + 1'b1;
         end
      end
   end

   // Data-valid lines up with the registered RAM output
   always_ff @(posedge pos_clk or negedge aresetn) begin
      if (!aresetn) begin
         dvld_q      <= 1'b0;
         underflow_q <= 1'b0;
      end else begin
         dvld_q      <= rd_accept;
         underflow_q <= rd_en_i & empty_i;   // Refused read
      end
   end

   assign rd_addr_o   = rd_addr_q;
   assign rd_accept_o = rd_accept;
   assign dvld_o      = dvld_q;
   assign underflow_o = underflow_q;

   // Empty is set only by a read that got in
   a_empty_after_read : assert property (@(posedge pos_clk) disable iff (!aresetn)
      $rose(empty_i) |-> $past(rd_accept));

endmodule

`default_nettype wire

//--- hdl/fifo_ram.sv
// FIFO storage
// Dual-port RAM, synchronous write and registered read
`timescale 1ns/1ps
`default_nettype none

module fifo_ram #(
   parameter int DATA_W = fifo_cfg_pkg::DEF_DATA_W,
   parameter int ADDR_W = fifo_cfg_pkg::DEF_ADDR_W
) (
   input  logic                    pos_clk,
   input  fifo_types_pkg::mem_wr_t mem_wr_i,
   input  logic                    rd_en_i,
   input  logic [ADDR_W-1:0]       rd_addr_i,
   output logic [DATA_W-1:0]       rd_data_o
);

   localparam int DEPTH = fifo_cfg_pkg::depth_of(ADDR_W);

   logic [DATA_W-1:0] mem [DEPTH];
   logic [DATA_W-1:0] rd_data_q;   // Holds the last word read

   always_ff @(posedge pos_clk) begin
      if (mem_wr_i.en) begin
         mem[mem_wr_i.addr] <= mem_wr_i.data;
      end
      if (rd_en_i) begin
         rd_data_q <= mem[rd_addr_i];   // Ready one edge later
      end
   end

   assign rd_data_o = rd_data_q;

endmodule

`default_nettype wire

//--- hdl/sync_fifo_top.sv
// Single-clock FIFO top level
// Sets the sizes and thresholds and wires the controllers, tracker and RAM
`timescale 1ns/1ps
`default_nettype none

module sync_fifo_top #(
   parameter int DATA_W     = fifo_cfg_pkg::DEF_DATA_W,
   parameter int ADDR_W     = fifo_cfg_pkg::DEF_ADDR_W,
   parameter int AFULL_VAL  = fifo_cfg_pkg::DEF_AFULL_VAL,
   parameter int AEMPTY_VAL = fifo_cfg_pkg::DEF_AEMPTY_VAL
) (
   input  logic                         pos_clk,
   input  logic                         aresetn,
   input  fifo_types_pkg::wr_req_t      wr_req_i,
   input  logic                         rd_en_i,
   output fifo_types_pkg::fifo_status_t status_o,
   output fifo_types_pkg::rd_resp_t     rd_resp_o,
   output logic                         wack_o,
   output logic                         overflow_o,
   output logic                         underflow_o
);

   fifo_types_pkg::mem_wr_t      mem_wr;
   fifo_types_pkg::fifo_status_t status;
   logic [ADDR_W-1:0]            rd_addr;
   logic [DATA_W-1:0]            rd_data;
   logic                         wr_accept;
   logic                         rd_accept;
   logic                         dvld;

   // ------------------------------------------------
   // Input side
   // ------------------------------------------------
   fifo_wr_ctrl #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) i_wr_ctrl (
      .pos_clk, .aresetn,
      .wr_req_i,
      .full_i      (status.full),
      .mem_wr_o    (mem_wr),
      .wr_accept_o (wr_accept),
      .wack_o, .overflow_o
   );

   // Level and flags
   fifo_occupancy #(.ADDR_W(ADDR_W), .AFULL_VAL(AFULL_VAL), .AEMPTY_VAL(AEMPTY_VAL)) i_occ (
      .pos_clk, .aresetn,
      .wr_accept_i (wr_accept),
      .rd_accept_i (rd_accept),
      .status_o    (status)
   );

   // ------------------------------------------------
   // Output side
   // ------------------------------------------------
   fifo_rd_ctrl #(.ADDR_W(ADDR_W)) i_rd_ctrl (
      .pos_clk, .aresetn,
      .rd_en_i,
      .empty_i     (status.empty),
      .rd_addr_o   (rd_addr),
      .rd_accept_o (rd_accept),
      .dvld_o      (dvld),
      .underflow_o
   );

   fifo_ram #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) i_ram (
      .pos_clk,
      .mem_wr_i  (mem_wr),
      .rd_en_i   (rd_accept),   // Only accepted reads touch the RAM
      .rd_addr_i (rd_addr),
      .rd_data_o (rd_data)
   );

   assign status_o       = status;
   assign rd_resp_o.dvld = dvld;
   assign rd_resp_o.data = rd_data;   // Meaningful only with dvld

endmodule

`default_nettype wire

//--- tb/fifo_checker.sv
// FIFO response checker
// Queue model of the FIFO, compares every DUT output once per cycle
`timescale 1ns/1ps
`default_nettype none

module fifo_checker #(
   parameter int DEPTH      = 1 << fifo_cfg_pkg::DEF_ADDR_W,
   parameter int AFULL_VAL  = fifo_cfg_pkg::DEF_AFULL_VAL,
   parameter int AEMPTY_VAL = fifo_cfg_pkg::DEF_AEMPTY_VAL
) (
   input  logic                         pos_clk,
   input  logic                         aresetn,
   input  fifo_types_pkg::wr_req_t      wr_req_i,
   input  logic                         rd_en_i,
   input  fifo_types_pkg::fifo_status_t status_i,
   input  fifo_types_pkg::rd_resp_t     rd_resp_i,
   input  logic                         wack_i,
   input  logic                         overflow_i,
   input  logic                         underflow_i,
   output int                           err_cnt_o,
   output int                           chk_cnt_o
);

   localparam int DW = fifo_types_pkg::DW;
   localparam int LW = fifo_types_pkg::LW;

   logic [DW-1:0]                model_q [$];   // Words in FIFO order
   fifo_types_pkg::fifo_status_t exp_status;
   logic                         exp_wack;
   logic                         exp_ovf;
   logic                         exp_udf;
   logic                         exp_dvld;
   logic [DW-1:0]                exp_data;
   logic                         is_full;
   logic                         is_empty;
   logic                         wr_acc;
   logic                         rd_acc;
   int                           err_cnt = 0;
   int                           chk_cnt = 0;

   // Status the flag rules give for a level
   function automatic fifo_types_pkg::fifo_status_t status_for(input int lvl);
      fifo_types_pkg::fifo_status_t s;
      s.full   = (lvl == DEPTH);
      s.afull  = (lvl >= AFULL_VAL);
      s.empty  = (lvl == 0);
      s.aempty = (lvl <= AEMPTY_VAL);
      s.level  = LW'(lvl);
      return s;
   endfunction

   task automatic check_val(input string what, input logic [15:0] got, input logic [15:0] exp);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("[FAIL] %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      end
   endtask

   // --------------------------------------------------
   // Compare, then predict the next edge
   // --------------------------------------------------
   // Negedge sampling, inputs and outputs both settled
   always @(negedge pos_clk) begin
      if (!aresetn) begin
         model_q.delete();
         exp_status = status_for(0);   // Reset values
         exp_wack   = 1'b0;
         exp_ovf    = 1'b0;
         exp_udf    = 1'b0;
         exp_dvld   = 1'b0;
         exp_data   = '0;
      end else begin
         check_val("full", status_i.full, exp_status.full);
         check_val("afull", status_i.afull, exp_status.afull);
         check_val("empty", status_i.empty, exp_status.empty);
         check_val("aempty", status_i.aempty, exp_status.aempty);
         check_val("level", status_i.level, exp_status.level);
         check_val("wack", wack_i, exp_wack);
         check_val("overflow", overflow_i, exp_ovf);
         check_val("underflow", underflow_i, exp_udf);
         check_val("dvld", rd_resp_i.dvld, exp_dvld);
         if (exp_dvld) begin
            check_val("read data", rd_resp_i.data, exp_data);   // Order check
         end

         is_full  = (model_q.size() == DEPTH);
         is_empty = (model_q.size() == 0);
         wr_acc   = wr_req_i.en && !is_full;   // Refused while full
         rd_acc   = rd_en_i && !is_empty;      // Refused while empty
         exp_wack = wr_acc;
         exp_ovf  = wr_req_i.en && is_full;
         exp_udf  = rd_en_i && is_empty;
         exp_dvld = rd_acc;
         if (rd_acc) begin
            exp_data = model_q.pop_front();    // Pop before push for read and write
         end
         if (wr_acc) begin
            model_q.push_back(wr_req_i.data);
         end
         exp_status = status_for(model_q.size());
      end
   end

   assign err_cnt_o = err_cnt;
   assign chk_cnt_o = chk_cnt;

endmodule

`default_nettype wire

//--- tb/tb_sync_fifo.sv
// Testbench for the single-clock FIFO
// Walks a table of operations with random write data, checker compares
`timescale 1ns/1ps
`default_nettype none

module tb_sync_fifo;

   localparam int CLK_PERIOD   = 20;
   localparam int RESET_CYCLES = 10;
   localparam int NSTEPS       = 14;
   localparam int DW           = fifo_types_pkg::DW;

   typedef enum logic [1:0] {OP_IDLE, OP_WRITE, OP_READ, OP_BOTH} op_e;

   typedef struct packed {
      op_e        op;
      logic [7:0] reps;   // Cycles to hold the operation
   } step_t;

   // --------------------------------------------------
   // Stimulus table
   // --------------------------------------------------
   step_t steps [NSTEPS] = '{
      '{OP_IDLE,  8'd2},
      '{OP_WRITE, 8'd20},   // Fill to full, last four overflow
      '{OP_READ,  8'd20},   // Drain in order, last four underflow
      '{OP_WRITE, 8'd8},
      '{OP_BOTH,  8'd10},   // Mid level, level holds
      '{OP_READ,  8'd8},
      '{OP_BOTH,  8'd3},    // From empty, first only writes
      '{OP_WRITE, 8'd15},
      '{OP_BOTH,  8'd3},    // From full, first only reads
      '{OP_READ,  8'd15},
      '{OP_WRITE, 8'd5},
      '{OP_BOTH,  8'd40},   // Long run through the address wrap
      '{OP_READ,  8'd6},
      '{OP_IDLE,  8'd2}
   };

   logic                         pos_clk = 1'b0;
   logic                         aresetn;
   fifo_types_pkg::wr_req_t      wr_req;
   logic                         rd_en;
   fifo_types_pkg::fifo_status_t status;
   fifo_types_pkg::rd_resp_t     rd_resp;
   logic                         wack;
   logic                         overflow;
   logic                         underflow;
   int                           err_cnt;
   int                           chk_cnt;

   always #(CLK_PERIOD / 2) pos_clk = ~pos_clk;

   sync_fifo_top i_dut (
      .pos_clk, .aresetn,
      .wr_req_i (wr_req), .rd_en_i (rd_en),
      .status_o (status), .rd_resp_o (rd_resp),
      .wack_o (wack), .overflow_o (overflow), .underflow_o (underflow)
   );

   fifo_checker i_checker (
      .pos_clk, .aresetn,
      .wr_req_i (wr_req), .rd_en_i (rd_en),
      .status_i (status), .rd_resp_i (rd_resp),
      .wack_i (wack), .overflow_i (overflow), .underflow_i (underflow),
      .err_cnt_o (err_cnt), .chk_cnt_o (chk_cnt)
   );

   // Sets the write and read requests for one cycle
   task automatic apply_op(input op_e op);
      wr_req.en   = (op == OP_WRITE) || (op == OP_BOTH);
      wr_req.data = wr_req.en ? DW'($urandom) : '0;   // Fresh word per write
      rd_en       = (op == OP_READ) || (op == OP_BOTH);
   endtask

   // --------------------------------------------------
   // Main sequence
   // --------------------------------------------------
   initial begin
      void'($urandom(64413));
      aresetn = 1'b0;
      wr_req  = '0;
      rd_en   = 1'b0;
      repeat (RESET_CYCLES) @(posedge pos_clk);
      #2 aresetn = 1'b1;

      for (int i = 0; i < NSTEPS; i++) begin
         for (int n = 0; n < int'(steps[i].reps); n++) begin
            @(posedge pos_clk);
            #2;                          // Clear of the edge
            apply_op(steps[i].op);
         end
      end
      @(posedge pos_clk);
      #2 apply_op(OP_IDLE);
      repeat (2) @(negedge pos_clk);     // Last responses compared
      #1;

      $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
      if (err_cnt == 0 && chk_cnt > 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

   // Run limit from the table length
   initial begin : watchdog
      int total_cycles;
      total_cycles = RESET_CYCLES + 50;
      foreach (steps[i]) begin
         total_cycles += int'(steps[i].reps);
      end
      #(total_cycles * CLK_PERIOD);
      $display("Timeout: the run did not finish within %0d cycles", total_cycles);
      $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- project.f
hdl/fifo_cfg_pkg.sv
hdl/fifo_types_pkg.sv
hdl/fifo_wr_ctrl.sv
hdl/fifo_occupancy.sv
hdl/fifo_rd_ctrl.sv
hdl/fifo_ram.sv
hdl/sync_fifo_top.sv
tb/fifo_checker.sv
tb/tb_sync_fifo.sv

//--- run.sh
#!/bin/sh
# Build and run the FIFO testbench with Verilator

cd "$(dirname "$0")" &&
verilator --binary -Wno-fatal --top-module tb_sync_fifo -f project.f -o sim_fifo &&
out="$(./obj_dir/sim_fifo)" ;
echo "$out" ;
echo "$out" | grep -q "All checks passed" && echo "PASS" || { echo "FAIL"; exit 1; }
